// File: data_port_ctrl.sv
`timescale 1ns/1ps

module data_port_ctrl (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           data_req_i,
  input  logic           data_we_i,
  input  mem_pkg::addr_t data_addr_i,
  input  mem_pkg::word_t data_wdata_i,
  input  mem_pkg::strb_t data_wstrb_i,
  output logic           data_ready_o,
  output logic           data_rvalid_o,
  output mem_pkg::word_t data_rdata_o,
  output logic           mem_req_o,
  output logic           mem_we_o,
  output mem_pkg::addr_t mem_addr_o,
  output mem_pkg::line_t mem_wdata_o,
  input  logic           mem_gnt_i,
  input  logic           mem_rvalid_i,
  input  mem_pkg::line_t mem_rdata_i
);

  mem_pkg::data_state_t           state_q;
  mem_pkg::data_state_t           state_d;
  logic                           accept;
  logic                           we_q;
  mem_pkg::addr_t                 addr_q;
  mem_pkg::word_t                 wdata_q;
  mem_pkg::strb_t                 strb_q;
  mem_pkg::line_t                 line_q;
  mem_pkg::line_t                 merged_line;
  logic [mem_pkg::WORD_SEL_W-1:0] word_idx;

  assign data_ready_o = (state_q == mem_pkg::DS_IDLE);
  assign accept       = data_req_i & data_ready_o;
  assign word_idx     = addr_q[mem_pkg::OFFSET_W-1:mem_pkg::BYTE_SEL_W];

  assign mem_req_o   = (state_q == mem_pkg::DS_READ_REQ) || (state_q == mem_pkg::DS_WRITE_REQ);
  assign mem_we_o    = (state_q == mem_pkg::DS_WRITE_REQ);
  assign mem_addr_o  = {addr_q[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W], {mem_pkg::OFFSET_W{1'b0}}};
  assign mem_wdata_o = line_q;

  assign data_rvalid_o = (state_q == mem_pkg::DS_RESP);
  assign data_rdata_o  = line_q[word_idx*mem_pkg::WORD_W +: mem_pkg::WORD_W];

  // Strobed bytes of the addressed word replace the fetched line
  always_comb begin
    merged_line = mem_rdata_i;
    for (int b = 0; b < mem_pkg::STRB_W; b++) begin
      if (strb_q[b]) begin
        merged_line[word_idx*mem_pkg::WORD_W + b*8 +: 8] = wdata_q[b*8 +: 8];
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      mem_pkg::DS_IDLE: begin
        // Writes also start with a line read
        if (accept) begin
          state_d = mem_pkg::DS_READ_REQ;
        end
      end
      mem_pkg::DS_READ_REQ: begin
        if (mem_gnt_i) begin
          state_d = mem_pkg::DS_READ_WAIT;
        end
      end
      mem_pkg::DS_READ_WAIT: begin
        if (mem_rvalid_i) begin
          state_d = we_q ? mem_pkg::DS_WRITE_REQ : mem_pkg::DS_RESP;
        end
      end
      mem_pkg::DS_WRITE_REQ: begin
        if (mem_gnt_i) begin
          state_d = mem_pkg::DS_WRITE_WAIT;
        end
      end
      mem_pkg::DS_WRITE_WAIT: begin
        if (mem_rvalid_i) begin
          state_d = mem_pkg::DS_RESP;
        end
      end
      default: state_d = mem_pkg::DS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      state_q <= mem_pkg::DS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q    <= data_we_i;
      addr_q  <= data_addr_i;
      wdata_q <= data_wdata_i;
      strb_q  <= data_wstrb_i;
    end
    if ((state_q == mem_pkg::DS_READ_WAIT) && mem_rvalid_i) begin
      line_q <= we_q ? merged_line : mem_rdata_i;
    end
  end

  // Routed responses arrive only while a line transaction is outstanding
  a_rvalid_in_wait: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_rvalid_i |-> (state_q == mem_pkg::DS_READ_WAIT) ||
                     (state_q == mem_pkg::DS_WRITE_WAIT))
    else $error("data port got a response with no line transaction outstanding");

endmodule

// File: fetch_line_buffer.sv
`timescale 1ns/1ps

module fetch_line_buffer (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           fetch_req_i,
  input  mem_pkg::addr_t fetch_addr_i,
  output logic           fetch_ready_o,
  output logic           fetch_rvalid_o,
  output mem_pkg::word_t fetch_rdata_o,
  output logic           mem_req_o,
  output mem_pkg::addr_t mem_addr_o,
  input  logic           mem_gnt_i,
  input  logic           mem_rvalid_i,
  input  mem_pkg::line_t mem_rdata_i
);

  mem_pkg::fetch_state_t            state_q;
  mem_pkg::fetch_state_t            state_d;
  logic                             valid_q;
  logic [mem_pkg::LINE_ADDR_W-1:0]  tag_q;
  mem_pkg::line_t                   line_q;
  mem_pkg::addr_t                   addr_q;
  logic                             accept;
  logic                             hit;
  logic [mem_pkg::WORD_SEL_W-1:0]   word_idx;
  mem_pkg::line_t                   src_line;

  assign fetch_ready_o = (state_q == mem_pkg::FS_IDLE);
  assign accept        = fetch_req_i & fetch_ready_o;
  assign hit = valid_q && (tag_q == fetch_addr_i[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W]);

  assign mem_req_o  = (state_q == mem_pkg::FS_MISS_REQ);
  assign mem_addr_o = {addr_q[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W], {mem_pkg::OFFSET_W{1'b0}}};

  // On a refill the word comes straight from the memory line
  assign word_idx       = addr_q[mem_pkg::OFFSET_W-1:mem_pkg::BYTE_SEL_W];
  assign src_line       = (state_q == mem_pkg::FS_MISS_WAIT) ? mem_rdata_i : line_q;
  assign fetch_rdata_o  = src_line[word_idx*mem_pkg::WORD_W +: mem_pkg::WORD_W];
  assign fetch_rvalid_o = (state_q == mem_pkg::FS_HIT_RESP) ||
                          ((state_q == mem_pkg::FS_MISS_WAIT) && mem_rvalid_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      mem_pkg::FS_IDLE: begin
        if (accept) begin
          state_d = hit ? mem_pkg::FS_HIT_RESP : mem_pkg::FS_MISS_REQ;
        end
      end
      mem_pkg::FS_MISS_REQ:  if (mem_gnt_i) state_d = mem_pkg::FS_MISS_WAIT;
      mem_pkg::FS_MISS_WAIT: if (mem_rvalid_i) state_d = mem_pkg::FS_IDLE;
      default:               state_d = mem_pkg::FS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      state_q <= mem_pkg::FS_IDLE;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if ((state_q == mem_pkg::FS_MISS_WAIT) && mem_rvalid_i) begin
        valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
    // Refill
    if ((state_q == mem_pkg::FS_MISS_WAIT) && mem_rvalid_i) begin
      line_q <= mem_rdata_i;
      tag_q  <= addr_q[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W];
    end
  end

  // Routed responses arrive only while a refill is outstanding
  a_rvalid_in_wait: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_rvalid_i |-> (state_q == mem_pkg::FS_MISS_WAIT))
    else $error("fetch buffer got a response with no refill outstanding");

endmodule

// File: line_arbiter.sv
`timescale 1ns/1ps

module line_arbiter (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           fetch_mem_req_i,
  input  mem_pkg::addr_t fetch_mem_addr_i,
  input  logic           data_mem_req_i,
  input  logic           data_mem_we_i,
  input  mem_pkg::addr_t data_mem_addr_i,
  input  mem_pkg::line_t data_mem_wdata_i,
  output logic           fetch_mem_gnt_o,
  output logic           fetch_mem_rvalid_o,
  output logic           data_mem_gnt_o,
  output logic           data_mem_rvalid_o,
  output logic           mem_req_o,
  output logic           mem_we_o,
  output mem_pkg::addr_t mem_addr_o,
  output mem_pkg::line_t mem_wdata_o,
  input  logic           mem_gnt_i,
  input  logic           mem_rvalid_i
);

  logic                            data_sel;
  logic                            fetch_sel;
  logic                            push;
  logic                            pop;
  mem_pkg::requester_t             push_owner;
  mem_pkg::requester_t             head_owner;
  mem_pkg::requester_t             order_q [mem_pkg::ORDER_DEPTH];
  logic [mem_pkg::ORDER_PTR_W-1:0] wr_ptr_q;
  logic [mem_pkg::ORDER_PTR_W-1:0] rd_ptr_q;
  logic [mem_pkg::ORDER_CNT_W-1:0] count_q;

  // Data side always wins
  assign data_sel  = data_mem_req_i;
  assign fetch_sel = fetch_mem_req_i & ~data_mem_req_i;

  assign mem_req_o   = data_sel | fetch_sel;
  assign mem_we_o    = data_sel & data_mem_we_i;
  assign mem_addr_o  = data_sel ? data_mem_addr_i : fetch_mem_addr_i;
  assign mem_wdata_o = data_mem_wdata_i;

  assign data_mem_gnt_o  = data_sel & mem_gnt_i;
  assign fetch_mem_gnt_o = fetch_sel & mem_gnt_i;

  // Owner of each granted request, oldest at the head
  assign push       = mem_req_o & mem_gnt_i;
  assign pop        = mem_rvalid_i;
  assign push_owner = data_sel ? mem_pkg::REQ_DATA : mem_pkg::REQ_FETCH;
  assign head_owner = order_q[rd_ptr_q];

  assign data_mem_rvalid_o  = pop & (head_owner == mem_pkg::REQ_DATA);
  assign fetch_mem_rvalid_o = pop & (head_owner == mem_pkg::REQ_FETCH);

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= push_owner;
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_i)
    push |-> (count_q != mem_pkg::ORDER_CNT_W'(mem_pkg::ORDER_DEPTH)))
    else $error("order FIFO overflow");

  a_no_rvalid_empty: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_rvalid_i |-> (count_q != '0))
    else $error("memory response with no request outstanding");

endmodule

// File: list.f
mem_pkg.sv
line_arbiter.sv
fetch_line_buffer.sv
data_port_ctrl.sv
mem_subsystem.sv
tb_line_memory.sv
tb_mem_subsystem.sv

// File: mem_pkg.sv
package mem_pkg;

  // Bus and line geometry
  localparam int ADDR_W         = 16;
  localparam int WORD_W         = 32;
  localparam int LINE_W         = 128;
  localparam int WORDS_PER_LINE = 4;
  localparam int OFFSET_W       = 4;
  localparam int STRB_W         = 4;

  localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;
  localparam int WORD_SEL_W  = $clog2(WORDS_PER_LINE);
  localparam int BYTE_SEL_W  = $clog2(STRB_W);

  // Arbiter order FIFO, one slot per client
  localparam int ORDER_DEPTH = 2;
  localparam int ORDER_PTR_W = $clog2(ORDER_DEPTH);
  localparam int ORDER_CNT_W = $clog2(ORDER_DEPTH + 1);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [STRB_W-1:0] strb_t;

  typedef enum logic {
    REQ_FETCH,
    REQ_DATA
  } requester_t;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_MISS_REQ,
    FS_MISS_WAIT,
    FS_HIT_RESP
  } fetch_state_t;

  typedef enum logic [2:0] {
    DS_IDLE,
    DS_READ_REQ,
    DS_READ_WAIT,
    DS_WRITE_REQ,
    DS_WRITE_WAIT,
    DS_RESP
  } data_state_t;

endpackage

// File: mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
  input  logic           clk_i,
  input  logic           rst_i,
  // Fetch port
  input  logic           fetch_req_i,
  input  mem_pkg::addr_t fetch_addr_i,
  output logic           fetch_ready_o,
  output logic           fetch_rvalid_o,
  output mem_pkg::word_t fetch_rdata_o,
  // Data port
  input  logic           data_req_i,
  input  logic           data_we_i,
  input  mem_pkg::addr_t data_addr_i,
  input  mem_pkg::word_t data_wdata_i,
  input  mem_pkg::strb_t data_wstrb_i,
  output logic           data_ready_o,
  output logic           data_rvalid_o,
  output mem_pkg::word_t data_rdata_o,
  // Line memory
  output logic           mem_req_o,
  output logic           mem_we_o,
  output mem_pkg::addr_t mem_addr_o,
  output mem_pkg::line_t mem_wdata_o,
  input  logic           mem_gnt_i,
  input  logic           mem_rvalid_i,
  input  mem_pkg::line_t mem_rdata_i
);

  logic           fetch_mem_req;
  mem_pkg::addr_t fetch_mem_addr;
  logic           fetch_mem_gnt;
  logic           fetch_mem_rvalid;
  logic           data_mem_req;
  logic           data_mem_we;
  mem_pkg::addr_t data_mem_addr;
  mem_pkg::line_t data_mem_wdata;
  logic           data_mem_gnt;
  logic           data_mem_rvalid;

  fetch_line_buffer u_fetch (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_rvalid_o (fetch_rvalid_o),
    .fetch_rdata_o  (fetch_rdata_o),
    .mem_req_o      (fetch_mem_req),
    .mem_addr_o     (fetch_mem_addr),
    .mem_gnt_i      (fetch_mem_gnt),
    .mem_rvalid_i   (fetch_mem_rvalid),
    .mem_rdata_i    (mem_rdata_i)
  );

  data_port_ctrl u_data (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .data_req_i    (data_req_i),
    .data_we_i     (data_we_i),
    .data_addr_i   (data_addr_i),
    .data_wdata_i  (data_wdata_i),
    .data_wstrb_i  (data_wstrb_i),
    .data_ready_o  (data_ready_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o),
    .mem_req_o     (data_mem_req),
    .mem_we_o      (data_mem_we),
    .mem_addr_o    (data_mem_addr),
    .mem_wdata_o   (data_mem_wdata),
    .mem_gnt_i     (data_mem_gnt),
    .mem_rvalid_i  (data_mem_rvalid),
    .mem_rdata_i   (mem_rdata_i)
  );

  line_arbiter u_arbiter (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .fetch_mem_req_i    (fetch_mem_req),
    .fetch_mem_addr_i   (fetch_mem_addr),
    .data_mem_req_i     (data_mem_req),
    .data_mem_we_i      (data_mem_we),
    .data_mem_addr_i    (data_mem_addr),
    .data_mem_wdata_i   (data_mem_wdata),
    .fetch_mem_gnt_o    (fetch_mem_gnt),
    .fetch_mem_rvalid_o (fetch_mem_rvalid),
    .data_mem_gnt_o     (data_mem_gnt),
    .data_mem_rvalid_o  (data_mem_rvalid),
    .mem_req_o          (mem_req_o),
    .mem_we_o           (mem_we_o),
    .mem_addr_o         (mem_addr_o),
    .mem_wdata_o        (mem_wdata_o),
    .mem_gnt_i          (mem_gnt_i),
    .mem_rvalid_i       (mem_rvalid_i)
  );

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_mem_subsystem -f list.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// File: tb_line_memory.sv
`timescale 1ns/1ps

module tb_line_memory (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           mem_req_i,
  input  logic           mem_we_i,
  input  mem_pkg::addr_t mem_addr_i,
  input  mem_pkg::line_t mem_wdata_i,
  output logic           mem_gnt_o,
  output logic           mem_rvalid_o,
  output mem_pkg::line_t mem_rdata_o
);

  localparam int LINES = 256;

  mem_pkg::line_t lines [LINES];
  mem_pkg::line_t resp_data_q [$];
  int             resp_due_q [$];
  int             gnt_wait;
  int             cyc;
  int             last_due;
  int             due;
  logic [7:0]     idx;

  assign mem_gnt_o = mem_req_i && (gnt_wait == 0);

  // Next grant delay is drawn when the current request is granted
  always @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      gnt_wait <= 0;
    end else if (mem_gnt_o) begin
      gnt_wait <= $urandom_range(3, 0);
    end else if (mem_req_i) begin
      gnt_wait <= gnt_wait - 1;
    end
  end

  always @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      mem_rvalid_o <= 1'b0;
      mem_rdata_o  <= '0;
      cyc      = 0;
      last_due = 0;
      resp_data_q.delete();
      resp_due_q.delete();
      // Word at byte address a holds (a * golden ratio) xor a fixed mask
      for (int l = 0; l < LINES; l++) begin
        for (int w = 0; w < mem_pkg::WORDS_PER_LINE; w++) begin
          lines[l][w*32 +: 32] = (32'(l * 16 + w * 4) * 32'h9e3779b9) ^ 32'h5a5aa5a5;
        end
      end
    end else begin
      cyc = cyc + 1;
      mem_rvalid_o <= 1'b0;
      if ((resp_due_q.size() > 0) && (resp_due_q[0] <= cyc)) begin
        mem_rvalid_o <= 1'b1;
        mem_rdata_o  <= resp_data_q.pop_front();
        void'(resp_due_q.pop_front());
      end
      if (mem_gnt_o) begin
        idx = mem_addr_i[11:4];
        due = cyc + int'($urandom_range(4, 1));
        // Keep responses in grant order
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        resp_data_q.push_back(lines[idx]);
        resp_due_q.push_back(due);
        if (mem_we_i) begin
          lines[idx] = mem_wdata_i;
        end
      end
    end
  end

endmodule

// File: tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

  // Code in 0x000-0x7ff, data in 0x800-0xfff
  localparam int CODE_BASE    = 'h000;
  localparam int DATA_BASE    = 'h800;
  localparam int REGION_WORDS = 512;
  localparam int N_TRANS      = 300;
  localparam int MAX_CYCLES   = N_TRANS * 40 + 8000;

  logic           clk_i;
  logic           rst_i;
  logic           fetch_req_i;
  mem_pkg::addr_t fetch_addr_i;
  logic           fetch_ready_o;
  logic           fetch_rvalid_o;
  mem_pkg::word_t fetch_rdata_o;
  logic           data_req_i;
  logic           data_we_i;
  mem_pkg::addr_t data_addr_i;
  mem_pkg::word_t data_wdata_i;
  mem_pkg::strb_t data_wstrb_i;
  logic           data_ready_o;
  logic           data_rvalid_o;
  mem_pkg::word_t data_rdata_o;
  logic           mem_req;
  logic           mem_we;
  mem_pkg::addr_t mem_addr;
  mem_pkg::line_t mem_wdata;
  logic           mem_gnt;
  logic           mem_rvalid;
  mem_pkg::line_t mem_rdata;

  mem_pkg::word_t shadow [1024];
  string          cur_test;
  int             errors;
  int             checks;
  int             err_before;
  int             tests_run;
  int             tests_failed;
  int             cyc;
  logic           no_mem_allowed;
  logic           fb_valid;
  logic [11:0]    fb_tag;
  logic           fetch_pending;
  logic           fetch_hit;
  int             fetch_acc_cyc;
  mem_pkg::word_t fetch_exp;
  logic           data_pending;
  logic           data_is_wr;
  mem_pkg::word_t data_exp;
  int             fetch_accepts;
  int             fetch_done;
  int             data_accepts;
  int             data_done;

  mem_subsystem UUT (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_rvalid_o (fetch_rvalid_o),
    .fetch_rdata_o  (fetch_rdata_o),
    .data_req_i     (data_req_i),
    .data_we_i      (data_we_i),
    .data_addr_i    (data_addr_i),
    .data_wdata_i   (data_wdata_i),
    .data_wstrb_i   (data_wstrb_i),
    .data_ready_o   (data_ready_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o),
    .mem_req_o      (mem_req),
    .mem_we_o       (mem_we),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_gnt_i      (mem_gnt),
    .mem_rvalid_i   (mem_rvalid),
    .mem_rdata_i    (mem_rdata)
  );

  tb_line_memory u_memory (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .mem_req_i    (mem_req),
    .mem_we_i     (mem_we),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (mem_wdata),
    .mem_gnt_o    (mem_gnt),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata)
  );

  initial begin
    clk_i = 1'b0;
  end

  always #10 clk_i = ~clk_i;

  function automatic mem_pkg::word_t init_word(input mem_pkg::addr_t a);
    return ({16'h0, a} * 32'h9e3779b9) ^ 32'h5a5aa5a5;
  endfunction

  function automatic mem_pkg::word_t merge_bytes(input mem_pkg::word_t old_w,
                                                 input mem_pkg::word_t new_w,
                                                 input mem_pkg::strb_t strb);
    mem_pkg::word_t r;
    r = old_w;
    for (int b = 0; b < mem_pkg::STRB_W; b++) begin
      if (strb[b]) begin
        r[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return r;
  endfunction

  function automatic mem_pkg::addr_t random_addr(input int base);
    return mem_pkg::addr_t'(base + 4 * int'($urandom_range(REGION_WORDS - 1, 0)));
  endfunction

  task automatic check_word(input string what, input mem_pkg::word_t exp,
                            input mem_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("Error in %s: %s", cur_test, msg);
  endtask

  // Compare process; expected values are taken at acceptance
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a transaction never completed", cyc);
      $display("SIMULATION FAILED");
      $finish;
    end else if (rst_i) begin
      if (no_mem_allowed && mem_req) begin
        note_failure("memory request issued while the fetch should hit");
      end
      if (fetch_rvalid_o) begin
        fetch_done++;
        if (!fetch_pending) begin
          note_failure("fetch response with no request in flight");
        end else begin
          fetch_pending = 1'b0;
          check_word("fetch data", fetch_exp, fetch_rdata_o);
          if (fetch_hit && (cyc != fetch_acc_cyc + 1)) begin
            note_failure($sformatf("fetch hit answered after %0d cycles, not 1",
                                   cyc - fetch_acc_cyc));
          end
        end
      end
      if (data_rvalid_o) begin
        data_done++;
        if (!data_pending) begin
          note_failure("data response with no request in flight");
        end else begin
          data_pending = 1'b0;
          if (!data_is_wr) begin
            check_word("data read", data_exp, data_rdata_o);
          end
        end
      end
      if (fetch_req_i && fetch_ready_o) begin
        fetch_accepts++;
        fetch_pending = 1'b1;
        fetch_acc_cyc = cyc;
        fetch_exp     = shadow[fetch_addr_i[11:2]];
        fetch_hit     = fb_valid && (fb_tag == fetch_addr_i[15:4]);
        fb_valid      = 1'b1;
        fb_tag        = fetch_addr_i[15:4];
      end
      if (data_req_i && data_ready_o) begin
        data_accepts++;
        data_pending = 1'b1;
        data_is_wr   = data_we_i;
        if (data_we_i) begin
          shadow[data_addr_i[11:2]] = merge_bytes(shadow[data_addr_i[11:2]],
                                                  data_wdata_i, data_wstrb_i);
        end else begin
          data_exp = shadow[data_addr_i[11:2]];
        end
      end
    end
  end

  task automatic fetch_word(input mem_pkg::addr_t a);
    @(negedge clk_i);
    while (!fetch_ready_o) begin
      @(negedge clk_i);
    end
    fetch_req_i  = 1'b1;
    fetch_addr_i = a;
    @(negedge clk_i);
    fetch_req_i = 1'b0;
  endtask

  task automatic data_access(input logic we, input mem_pkg::addr_t a,
                             input mem_pkg::word_t wd, input mem_pkg::strb_t strb);
    @(negedge clk_i);
    while (!data_ready_o) begin
      @(negedge clk_i);
    end
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_addr_i  = a;
    data_wdata_i = wd;
    data_wstrb_i = strb;
    @(negedge clk_i);
    data_req_i = 1'b0;
  endtask

  task automatic wait_quiet();
    @(negedge clk_i);
    while (fetch_pending || data_pending || !fetch_ready_o || !data_ready_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test   = name;
    err_before = errors;
  endtask

  task automatic end_test();
    wait_quiet();
    tests_run++;
    if (errors > err_before) begin
      tests_failed++;
      $display("Test %s: FAIL", cur_test);
    end else begin
      $display("Test %s: PASS", cur_test);
    end
  endtask

  initial begin
    mem_pkg::addr_t a;
    mem_pkg::addr_t line_base;
    void'($urandom(32'h6bf2));
    rst_i          = 1'b0;
    fetch_req_i    = 1'b0;
    fetch_addr_i   = '0;
    data_req_i     = 1'b0;
    data_we_i      = 1'b0;
    data_addr_i    = '0;
    data_wdata_i   = '0;
    data_wstrb_i   = '0;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    cyc            = 0;
    no_mem_allowed = 1'b0;
    fb_valid       = 1'b0;
    fb_tag         = '0;
    fetch_pending  = 1'b0;
    data_pending   = 1'b0;
    fetch_accepts  = 0;
    fetch_done     = 0;
    data_accepts   = 0;
    data_done      = 0;
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = init_word(mem_pkg::addr_t'(i * 4));
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;

    begin_test("reset");
    @(negedge clk_i);
    checks++;
    if (!fetch_ready_o || !data_ready_o || mem_req || fetch_rvalid_o || data_rvalid_o) begin
      note_failure("outputs not in their idle values after reset");
    end
    end_test();

    begin_test("fetch_miss");
    for (int i = 0; i < 32; i++) begin
      fetch_word(mem_pkg::addr_t'(CODE_BASE + ((i * 3) % 128) * 16 + (i % 4) * 4));
    end
    end_test();

    begin_test("fetch_hit");
    for (int i = 0; i < 8; i++) begin
      line_base = mem_pkg::addr_t'(CODE_BASE + (90 + i * 5) * 16);
      fetch_word(line_base);
      wait_quiet();
      no_mem_allowed = 1'b1;
      fetch_word(line_base + 16'd12);
      fetch_word(line_base + 16'd4);
      fetch_word(line_base);
      fetch_word(line_base + 16'd8);
      wait_quiet();
      no_mem_allowed = 1'b0;
    end
    end_test();

    begin_test("data_read");
    for (int i = 0; i < 32; i++) begin
      data_access(1'b0, random_addr(DATA_BASE), '0, '0);
    end
    end_test();

    begin_test("data_write");
    for (int i = 0; i < 24; i++) begin
      a = random_addr(DATA_BASE);
      data_access(1'b1, a, $urandom, mem_pkg::strb_t'($urandom_range(15, 0)));
      data_access(1'b0, a, '0, '0);
      // Neighbours in the same line must be unchanged
      for (int w = 0; w < mem_pkg::WORDS_PER_LINE; w++) begin
        if (w != int'(a[3:2])) begin
          data_access(1'b0, {a[15:4], 4'(w * 4)}, '0, '0);
        end
      end
    end
    end_test();

    begin_test("concurrent");
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          fetch_word(random_addr(CODE_BASE));
        end
      end
      begin
        for (int i = 0; i < 40; i++) begin
          data_access(1'($urandom_range(1, 0)), random_addr(DATA_BASE), $urandom,
                      mem_pkg::strb_t'($urandom_range(15, 0)));
        end
      end
    join
    wait_quiet();
    checks++;
    if ((fetch_accepts != fetch_done) || (data_accepts != data_done)) begin
      note_failure($sformatf("completions differ from acceptances (fetch %0d/%0d, data %0d/%0d)",
                             fetch_done, fetch_accepts, data_done, data_accepts));
    end
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if ((errors == 0) && (tests_failed == 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
